//--- list.f
source/cluster_periph_pkg.sv
source/periph_bus_demux.sv
source/cluster_ctrl_unit.sv
source/cluster_timer.sv
source/event_unit.sv
source/cluster_periph_top.sv
sim/tb_asserts.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench, then look for the fail message in the log
rm -f sim.log
verilator --binary --assert --timing -f list.f --top-module tb_top -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "TEST FAIL" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "Simulation failed"; exit 1; } || { echo "Simulation passed"; exit 0; }

//--- sim/tb_top.sv
//******************************
// Cluster peripheral testbench
//******************************

`timescale 1ns/10ps
`default_nettype none

module tb_top
  import cluster_periph_pkg::*;
();

  localparam int CLK_PERIOD    = 4;
  localparam int RST_CYCLES    = 16;
  localparam int T1_OPS        = 150;
  localparam int T2_OPS        = 120;
  localparam int T3_OPS        = 200;
  localparam int T4_ROUNDS     = 8;
  localparam int T4_MAX_WAIT   = 48;
  localparam int T4_ROUND_LEN  = T4_MAX_WAIT + 16;
  localparam int T5_CYCLES     = 400;
  localparam int TEST_GAP      = 8;
  localparam int MARGIN        = 100;
  // Every bus operation takes at most two cycles
  localparam int TOTAL_CYCLES  = RST_CYCLES + 2 * T1_OPS + 2 * T2_OPS + T3_OPS
                               + T4_ROUNDS * T4_ROUND_LEN + T5_CYCLES + 5 * TEST_GAP;

  integer seed = 32'h6e37;

  logic                                  clk_i;
  logic                                  arst_n_i;
  logic                                  req_i;
  logic [DATA_WIDTH-1:0]                 add_i;
  logic                                  wen_i;
  logic [DATA_WIDTH-1:0]                 wdata_i;
  logic [ID_WIDTH-1:0]                   id_i;
  logic                                  gnt_o;
  logic                                  r_valid_o;
  logic [DATA_WIDTH-1:0]                 r_rdata_o;
  logic                                  r_opc_o;
  logic [ID_WIDTH-1:0]                   r_id_o;
  logic                                  mbox_irq_i;
  logic [NB_CORES-1:0]                   dma_event_i;
  logic [NB_CORES-1:0]                   dma_irq_i;
  logic                                  eoc_o;
  logic [NB_CORES-1:0]                   fetch_enable_o;
  logic [NB_CORES-1:0][DATA_WIDTH-1:0]   boot_addr_o;
  logic [NB_CORES-1:0]                   irq_req_o;
  logic [NB_CORES-1:0][IRQ_ID_WIDTH-1:0] irq_id_o;
  logic [NB_CORES-1:0]                   irq_ack_i;
  logic [NB_CORES-1:0][IRQ_ID_WIDTH-1:0] irq_ack_id_i;

  cluster_periph_top cluster_periph_top_i (.*);

  tb_checker tb_checker_i (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // One bus request in the next cycle
  task automatic bus_op(input logic wr, input logic [1:0] unit, input logic [7:0] idx,
                        input logic [31:0] data);
    logic [31:0] rnd;
    rnd = $random(seed);
    @(posedge clk_i);
    req_i   <= 1'b1;
    wen_i   <= ~wr;
    add_i   <= {20'h0, unit, idx, 2'b00};
    wdata_i <= data;
    id_i    <= rnd[ID_WIDTH-1:0];
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      req_i <= 1'b0;
    end
  endtask

  task automatic end_test();
    idle(3);
    @(negedge clk_i);
    tb_checker_i.finish_test();
  endtask

  //******************************
  // Stimulus
  //******************************
  initial begin
    logic [31:0] r;
    logic [7:0]  idx;
    int          wait_cycles;
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    req_i        = 1'b0;
    add_i        = '0;
    wen_i        = 1'b1;
    wdata_i      = '0;
    id_i         = '0;
    mbox_irq_i   = 1'b0;
    dma_event_i  = '0;
    dma_irq_i    = '0;
    irq_ack_i    = '0;
    irq_ack_id_i = '0;
    repeat (RST_CYCLES) @(posedge clk_i);
    arst_n_i <= 1'b1;
    idle(2);

    tb_checker_i.start_test("control registers");
    repeat (T1_OPS) begin
      r = $random(seed);
      case (r[1:0])
        2'd0:    idx = 8'(CTRL_EOC);
        2'd1:    idx = 8'(CTRL_FETCH_EN);
        default: idx = 8'(CTRL_BOOT_ADDR) + {6'd0, r[3:2]};
      endcase
      bus_op(r[4], 2'(UNIT_CTRL), idx, $random(seed));
      if (r[5]) idle(1);
    end
    end_test();

    tb_checker_i.start_test("error responses");
    repeat (T2_OPS) begin
      r = $random(seed);
      case (r[1:0])
        2'd0: begin
          idx = r[15:8];
          while (idx == 8'd0 || idx == 8'd2 || (idx >= 8'd16 && idx < 8'd20)) begin
            idx = 8'($random(seed));
          end
        end
        2'd1: idx = 8'd3 + {1'b0, r[14:8]};
        2'd2: idx = r[7] ? {r[13:8], 2'b11} : 8'd16 + {3'b0, r[12:8]};
        default: idx = r[15:8];
      endcase
      bus_op(r[4], r[1:0], idx, $random(seed));
      if (r[5]) idle(1);
    end
    end_test();

    tb_checker_i.start_test("pipelined access");
    repeat (T3_OPS) begin
      r = $random(seed);
      bus_op(r[7], r[1:0], {3'b0, r[6:2]}, $random(seed));
    end
    end_test();

    tb_checker_i.start_test("timer");
    repeat (T4_ROUNDS) begin
      r = $random(seed);
      wait_cycles = 1 + int'(r[15:8]) % T4_MAX_WAIT;
      bus_op(1'b1, 2'(UNIT_TIMER), 8'(TIMER_CMP), {28'd0, r[3:0]});
      bus_op(1'b1, 2'(UNIT_TIMER), 8'(TIMER_COUNT), 32'd0);
      bus_op(1'b1, 2'(UNIT_TIMER), 8'(TIMER_CFG), 32'd1);
      idle(wait_cycles);
      bus_op(1'b1, 2'(UNIT_TIMER), 8'(TIMER_CFG), 32'd0);
      bus_op(1'b0, 2'(UNIT_TIMER), 8'(TIMER_COUNT), 32'd0);
      for (int c = 0; c < NB_CORES; c++) begin
        bus_op(1'b0, 2'(UNIT_EVENT), 8'(4 * c + 1), 32'd0);
        bus_op(1'b1, 2'(UNIT_EVENT), 8'(4 * c + 2), 32'hF);
      end
      idle(1);
    end
    end_test();

    tb_checker_i.start_test("interrupts");
    repeat (T5_CYCLES) begin
      r = $random(seed);
      @(posedge clk_i);
      mbox_irq_i   <= (r[2:0] == 3'd0);
      dma_event_i  <= r[7:4] & r[11:8];
      dma_irq_i    <= r[15:12] & r[27:24] & r[31:28];
      irq_ack_i    <= irq_req_o & r[19:16];
      irq_ack_id_i <= irq_id_o;
      req_i        <= (r[22:20] < 3'd3);
      wen_i        <= (r[22:20] == 3'd1);
      add_i        <= {20'h0, 2'(UNIT_EVENT), 4'd0, r[24:23], 2'(r[22:20]), 2'b00};
      wdata_i      <= {28'd0, r[31:28]};
      id_i         <= r[ID_WIDTH+7:8];
    end
    @(posedge clk_i);
    mbox_irq_i  <= 1'b0;
    dma_event_i <= '0;
    dma_irq_i   <= '0;
    irq_ack_i   <= '0;
    req_i       <= 1'b0;
    end_test();

    tb_checker_i.report_counts();
    if (tb_checker_i.errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TOTAL_CYCLES * CLK_PERIOD + MARGIN * CLK_PERIOD);
    $display("Timeout: the tests did not finish in the expected time");
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/tb_checker.sv
//******************************
// Reference model and checks
//******************************

`timescale 1ns/10ps
`default_nettype none

module tb_checker
  import cluster_periph_pkg::*;
(
  input logic                                  clk_i,
  input logic                                  arst_n_i,
  input logic                                  req_i,
  input logic [DATA_WIDTH-1:0]                 add_i,
  input logic                                  wen_i,
  input logic [DATA_WIDTH-1:0]                 wdata_i,
  input logic [ID_WIDTH-1:0]                   id_i,
  input logic                                  gnt_o,
  input logic                                  r_valid_o,
  input logic [DATA_WIDTH-1:0]                 r_rdata_o,
  input logic                                  r_opc_o,
  input logic [ID_WIDTH-1:0]                   r_id_o,
  input logic                                  mbox_irq_i,
  input logic [NB_CORES-1:0]                   dma_event_i,
  input logic [NB_CORES-1:0]                   dma_irq_i,
  input logic                                  eoc_o,
  input logic [NB_CORES-1:0]                   fetch_enable_o,
  input logic [NB_CORES-1:0][DATA_WIDTH-1:0]   boot_addr_o,
  input logic [NB_CORES-1:0]                   irq_req_o,
  input logic [NB_CORES-1:0][IRQ_ID_WIDTH-1:0] irq_id_o,
  input logic [NB_CORES-1:0]                   irq_ack_i,
  input logic [NB_CORES-1:0][IRQ_ID_WIDTH-1:0] irq_ack_id_i
);

  int unsigned errors       = 0;
  int unsigned test_errors  = 0;
  int unsigned tests_run    = 0;
  int unsigned tests_failed = 0;
  string       test_name    = "";

  // Model state, always the value before the current edge
  logic                  eoc_m;
  logic [NB_CORES-1:0]   fetch_m;
  logic [31:0]           boot_m [NB_CORES];
  logic                  en_m;
  logic                  tev_m;
  logic [31:0]           count_m;
  logic [31:0]           cmp_m;
  logic [3:0]            mask_m [NB_CORES];
  logic [3:0]            buf_m  [NB_CORES];
  logic                  rv_m;
  logic                  ropc_m;
  logic [31:0]           rdata_m;
  logic [ID_WIDTH-1:0]   rid_m;

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors != 0) tests_failed++;
    $display("Test %0d %s: %s (%0d errors)", tests_run, test_name,
             (test_errors == 0) ? "ok" : "failed", test_errors);
  endtask

  task automatic report_counts();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("Error %s expected %h got %h at %0t ns", name, exp, got, $time);
      errors++;
      test_errors++;
    end
  endtask

  task automatic reset_model();
    eoc_m   = 1'b0;
    fetch_m = '0;
    en_m    = 1'b0;
    tev_m   = 1'b0;
    count_m = '0;
    cmp_m   = '0;
    rv_m    = 1'b0;
    for (int c = 0; c < NB_CORES; c++) begin
      boot_m[c] = BOOT_ADDR_RESET;
      mask_m[c] = '0;
      buf_m[c]  = '0;
    end
  endtask

  task automatic compare_outputs();
    logic [3:0] pend;
    int         low;
    check_val("gnt_o", 32'(req_i), 32'(gnt_o));
    check_val("r_valid_o", 32'(rv_m), 32'(r_valid_o));
    if (rv_m) begin
      check_val("r_id_o", 32'(rid_m), 32'(r_id_o));
      check_val("r_opc_o", 32'(ropc_m), 32'(r_opc_o));
      check_val("r_rdata_o", rdata_m, r_rdata_o);
    end
    check_val("eoc_o", 32'(eoc_m), 32'(eoc_o));
    check_val("fetch_enable_o", 32'(fetch_m), 32'(fetch_enable_o));
    for (int c = 0; c < NB_CORES; c++) begin
      pend = buf_m[c] & mask_m[c];
      low  = 0;
      for (int k = NB_EVENTS - 1; k >= 0; k--) begin
        if (pend[k]) low = k;
      end
      check_val($sformatf("boot_addr_o[%0d]", c), boot_m[c], boot_addr_o[c]);
      check_val($sformatf("irq_req_o[%0d]", c), 32'(|pend), 32'(irq_req_o[c]));
      if (pend != 4'd0) begin
        check_val($sformatf("irq_id_o[%0d]", c), 32'(IRQ_ID_BASE) + 32'(low), 32'(irq_id_o[c]));
      end
    end
  endtask

  //******************************
  // Model step at each edge
  //******************************
  task automatic step_model();
    logic        err;
    logic        wr;
    logic        match;
    logic [31:0] rd;
    logic [1:0]  unit;
    logic [7:0]  idx;
    logic [3:0]  evt;
    logic [3:0]  ack;
    logic [3:0]  clr;
    int          core;
    int          aid;
    wr   = req_i && !wen_i;
    unit = add_i[11:10];
    idx  = add_i[9:2];
    core = int'(idx[7:2]);
    err  = 1'b1;
    rd   = '0;
    case (unit)
      2'd0: begin
        if (idx == 8'd0) begin
          err = 1'b0;
          rd  = 32'(eoc_m);
        end else if (idx == 8'd2) begin
          err = 1'b0;
          rd  = 32'(fetch_m);
        end else if (idx >= 8'd16 && idx < 8'd20) begin
          err = 1'b0;
          rd  = boot_m[int'(idx) - 16];
        end
      end
      2'd1: begin
        err = (idx > 8'd2);
        if (idx == 8'd0) rd = 32'(en_m);
        if (idx == 8'd1) rd = count_m;
        if (idx == 8'd2) rd = cmp_m;
      end
      2'd2: begin
        if (core < NB_CORES && idx[1:0] != 2'd3) begin
          err = 1'b0;
          if (idx[1:0] == 2'd0) rd = 32'(mask_m[core]);
          if (idx[1:0] == 2'd1) rd = 32'(buf_m[core]);
        end
      end
      default: err = 1'b1;
    endcase
    rv_m = req_i;
    if (req_i) begin
      rid_m   = id_i;
      ropc_m  = err;
      rdata_m = (err || wr) ? 32'd0 : rd;
    end

    for (int c = 0; c < NB_CORES; c++) begin
      evt = {dma_irq_i[c], dma_event_i[c], tev_m, mbox_irq_i};
      ack = '0;
      aid = int'(irq_ack_id_i[c]) - int'(IRQ_ID_BASE);
      if (irq_ack_i[c] && aid >= 0 && aid < NB_EVENTS) ack[aid] = 1'b1;
      clr = '0;
      if (wr && !err && unit == 2'd2 && core == c && idx[1:0] == 2'd2) clr = wdata_i[3:0];
      buf_m[c] = (buf_m[c] & ~ack & ~clr) | evt;
      if (wr && !err && unit == 2'd2 && core == c && idx[1:0] == 2'd0) mask_m[c] = wdata_i[3:0];
    end

    // Timer counts only once the enable is already set
    match = en_m && (count_m == cmp_m);
    tev_m = match;
    if (wr && unit == 2'd1 && idx == 8'd1) count_m = wdata_i;
    else if (match) count_m = '0;
    else if (en_m) count_m = count_m + 32'd1;
    if (wr && unit == 2'd1 && idx == 8'd0) en_m = wdata_i[0];
    if (wr && unit == 2'd1 && idx == 8'd2) cmp_m = wdata_i;

    if (wr && !err && unit == 2'd0) begin
      if (idx == 8'd0) eoc_m = wdata_i[0];
      else if (idx == 8'd2) fetch_m = wdata_i[NB_CORES-1:0];
      else boot_m[int'(idx) - 16] = wdata_i;
    end
  endtask

  always @(posedge clk_i) begin
    if (!arst_n_i) begin
      reset_model();
    end else begin
      compare_outputs();
      step_model();
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_asserts.sv
//******************************
// Bus and interrupt assertions
//******************************

`timescale 1ns/10ps
`default_nettype none

module tb_asserts
  import cluster_periph_pkg::*;
(
  input logic                                  clk_i,
  input logic                                  arst_n_i,
  input logic                                  req_i,
  input logic                                  gnt_o,
  input logic [ID_WIDTH-1:0]                   id_i,
  input logic                                  r_valid_o,
  input logic [ID_WIDTH-1:0]                   r_id_o,
  input logic [NB_CORES-1:0]                   irq_req_o,
  input logic [NB_CORES-1:0][IRQ_ID_WIDTH-1:0] irq_id_o
);

  // Response one cycle after each grant, same id
  resp_follows_grant: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req_i && gnt_o) |=> (r_valid_o && r_id_o == $past(id_i)))
    else $error("response missing or with a wrong id after a grant");

  no_valid_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !r_valid_o)
    else $error("response valid while in reset");

  for (genvar i = 0; i < NB_CORES; i++) begin : gen_irq
    irq_id_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      irq_req_o[i] |-> (irq_id_o[i] >= IRQ_ID_WIDTH'(IRQ_ID_BASE)))
      else $error("interrupt id below the event base");
  end

endmodule

bind cluster_periph_top tb_asserts tb_asserts_i (.*);

`default_nettype wire

//--- source/cluster_periph_top.sv
//******************************
// Cluster peripherals
//******************************

`timescale 1ns/10ps
`default_nettype none

module cluster_periph_top
  import cluster_periph_pkg::*;
(
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,

  // Peripheral bus
  input  logic                                     req_i,
  input  logic [DATA_WIDTH-1:0]                    add_i,
  input  logic                                     wen_i,
  input  logic [DATA_WIDTH-1:0]                    wdata_i,
  input  logic [ID_WIDTH-1:0]                      id_i,
  output logic                                     gnt_o,
  output logic                                     r_valid_o,
  output logic [DATA_WIDTH-1:0]                    r_rdata_o,
  output logic                                     r_opc_o,
  output logic [ID_WIDTH-1:0]                      r_id_o,

  // Event sources
  input  logic                                     mbox_irq_i,
  input  logic [NB_CORES-1:0]                      dma_event_i,
  input  logic [NB_CORES-1:0]                      dma_irq_i,

  // Core control
  output logic                                     eoc_o,
  output logic [NB_CORES-1:0]                      fetch_enable_o,
  output logic [NB_CORES-1:0][DATA_WIDTH-1:0]      boot_addr_o,

  // Core interrupts
  output logic [NB_CORES-1:0]                      irq_req_o,
  output logic [NB_CORES-1:0][IRQ_ID_WIDTH-1:0]    irq_id_o,
  input  logic [NB_CORES-1:0]                      irq_ack_i,
  input  logic [NB_CORES-1:0][IRQ_ID_WIDTH-1:0]    irq_ack_id_i
);

  logic                     ctrl_req;
  logic                     timer_req;
  logic                     eu_req;
  logic                     unit_write;
  logic [REG_IDX_WIDTH-1:0] unit_reg_idx;
  logic [DATA_WIDTH-1:0]    unit_wdata;
  logic [DATA_WIDTH-1:0]    ctrl_rdata;
  logic [DATA_WIDTH-1:0]    timer_rdata;
  logic [DATA_WIDTH-1:0]    eu_rdata;
  logic                     ctrl_bad_reg;
  logic                     timer_bad_reg;
  logic                     eu_bad_reg;
  logic                     timer_event;

  //******************************
  // Bus demultiplexer
  //******************************
  periph_bus_demux periph_bus_demux_i (
    .clk_i           ( clk_i         ),
    .arst_n_i        ( arst_n_i      ),
    .req_i           ( req_i         ),
    .add_i           ( add_i         ),
    .wen_i           ( wen_i         ),
    .wdata_i         ( wdata_i       ),
    .id_i            ( id_i          ),
    .gnt_o           ( gnt_o         ),
    .r_valid_o       ( r_valid_o     ),
    .r_rdata_o       ( r_rdata_o     ),
    .r_opc_o         ( r_opc_o       ),
    .r_id_o          ( r_id_o        ),
    .ctrl_req_o      ( ctrl_req      ),
    .timer_req_o     ( timer_req     ),
    .eu_req_o        ( eu_req        ),
    .write_o         ( unit_write    ),
    .reg_idx_o       ( unit_reg_idx  ),
    .wdata_o         ( unit_wdata    ),
    .ctrl_rdata_i    ( ctrl_rdata    ),
    .ctrl_bad_reg_i  ( ctrl_bad_reg  ),
    .timer_rdata_i   ( timer_rdata   ),
    .timer_bad_reg_i ( timer_bad_reg ),
    .eu_rdata_i      ( eu_rdata      ),
    .eu_bad_reg_i    ( eu_bad_reg    )
  );

  //******************************
  // Control unit
  //******************************
  cluster_ctrl_unit cluster_ctrl_unit_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .req_i          ( ctrl_req       ),
    .write_i        ( unit_write     ),
    .reg_idx_i      ( unit_reg_idx   ),
    .wdata_i        ( unit_wdata     ),
    .rdata_o        ( ctrl_rdata     ),
    .bad_reg_o      ( ctrl_bad_reg   ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  //******************************
  // Timer
  //******************************
  cluster_timer cluster_timer_i (
    .clk_i     ( clk_i         ),
    .arst_n_i  ( arst_n_i      ),
    .req_i     ( timer_req     ),
    .write_i   ( unit_write    ),
    .reg_idx_i ( unit_reg_idx  ),
    .wdata_i   ( unit_wdata    ),
    .rdata_o   ( timer_rdata   ),
    .bad_reg_o ( timer_bad_reg ),
    .event_o   ( timer_event   )
  );

  //******************************
  // Event unit
  //******************************
  event_unit event_unit_i (
    .clk_i         ( clk_i        ),
    .arst_n_i      ( arst_n_i     ),
    .req_i         ( eu_req       ),
    .write_i       ( unit_write   ),
    .reg_idx_i     ( unit_reg_idx ),
    .wdata_i       ( unit_wdata   ),
    .mbox_irq_i    ( mbox_irq_i   ),
    .timer_event_i ( timer_event  ),
    .dma_event_i   ( dma_event_i  ),
    .dma_irq_i     ( dma_irq_i    ),
    .irq_ack_i     ( irq_ack_i    ),
    .irq_ack_id_i  ( irq_ack_id_i ),
    .rdata_o       ( eu_rdata     ),
    .bad_reg_o     ( eu_bad_reg   ),
    .irq_req_o     ( irq_req_o    ),
    .irq_id_o      ( irq_id_o     )
  );

endmodule

`default_nettype wire

//--- source/event_unit.sv
//******************************
// Event unit
//******************************

`timescale 1ns/10ps
`default_nettype none

module event_unit
  import cluster_periph_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  req_i,
  input  logic                                  write_i,
  input  logic [REG_IDX_WIDTH-1:0]              reg_idx_i,
  input  logic [DATA_WIDTH-1:0]                 wdata_i,
  input  logic                                  mbox_irq_i,
  input  logic                                  timer_event_i,
  input  logic [NB_CORES-1:0]                   dma_event_i,
  input  logic [NB_CORES-1:0]                   dma_irq_i,
  input  logic [NB_CORES-1:0]                   irq_ack_i,
  input  logic [NB_CORES-1:0][IRQ_ID_WIDTH-1:0] irq_ack_id_i,
  output logic [DATA_WIDTH-1:0]                 rdata_o,
  output logic                                  bad_reg_o,
  output logic [NB_CORES-1:0]                   irq_req_o,
  output logic [NB_CORES-1:0][IRQ_ID_WIDTH-1:0] irq_id_o
);

  logic [NB_EVENTS-1:0]       mask_q [NB_CORES];
  logic [NB_EVENTS-1:0]       buf_q  [NB_CORES];
  logic [REG_IDX_WIDTH-3:0]   core_sel;
  eu_reg_e                    reg_off;

  // Word index splits into core number and register offset
  assign core_sel = reg_idx_i[REG_IDX_WIDTH-1:2];
  assign reg_off  = eu_reg_e'(reg_idx_i[1:0]);

  always_comb begin
    rdata_o   = '0;
    bad_reg_o = 1'b1;
    for (int i = 0; i < NB_CORES; i++) begin
      if (core_sel == (REG_IDX_WIDTH-2)'(i)) begin
        case (reg_off)
          EU_MASK: begin
            rdata_o   = DATA_WIDTH'(mask_q[i]);
            bad_reg_o = 1'b0;
          end
          EU_BUFFER: begin
            rdata_o   = DATA_WIDTH'(buf_q[i]);
            bad_reg_o = 1'b0;
          end
          // Clear register is write-only and reads as zero
          EU_BUFFER_CLEAR: bad_reg_o = 1'b0;
          default:         bad_reg_o = 1'b1;
        endcase
      end
    end
  end

  //******************************
  // Per-core event logic
  //******************************
  for (genvar i = 0; i < NB_CORES; i++) begin : gen_core
    logic [NB_EVENTS-1:0]    evt_in;
    logic [NB_EVENTS-1:0]    ack_clr;
    logic [NB_EVENTS-1:0]    sw_clr;
    logic [NB_EVENTS-1:0]    pending;
    logic [IRQ_ID_WIDTH-1:0] lowest;
    logic                    core_wr;

    assign evt_in[EVT_MBOX]    = mbox_irq_i;
    assign evt_in[EVT_TIMER]   = timer_event_i;
    assign evt_in[EVT_DMA]     = dma_event_i[i];
    assign evt_in[EVT_DMA_IRQ] = dma_irq_i[i];

    assign core_wr = req_i && write_i && (core_sel == (REG_IDX_WIDTH-2)'(i));
    assign sw_clr  = (core_wr && reg_off == EU_BUFFER_CLEAR) ? wdata_i[NB_EVENTS-1:0] : '0;

    // Acknowledged id back to its buffer bit
    always_comb begin
      ack_clr = '0;
      for (int k = 0; k < NB_EVENTS; k++) begin
        if (irq_ack_i[i] && irq_ack_id_i[i] == IRQ_ID_WIDTH'(IRQ_ID_BASE + k)) begin
          ack_clr[k] = 1'b1;
        end
      end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        mask_q[i] <= '0;
        buf_q[i]  <= '0;
      end else begin
        if (core_wr && reg_off == EU_MASK) begin
          mask_q[i] <= wdata_i[NB_EVENTS-1:0];
        end
        // A new event beats a clear at the same edge
        buf_q[i] <= (buf_q[i] & ~ack_clr & ~sw_clr) | evt_in;
      end
    end

    assign pending = buf_q[i] & mask_q[i];

    // Lowest pending bit has priority
    always_comb begin
      lowest = '0;
      for (int k = NB_EVENTS - 1; k >= 0; k--) begin
        if (pending[k]) begin
          lowest = IRQ_ID_WIDTH'(k);
        end
      end
    end

    assign irq_req_o[i] = |pending;
    assign irq_id_o[i]  = IRQ_ID_WIDTH'(IRQ_ID_BASE) + lowest;
  end

endmodule

`default_nettype wire

//--- source/cluster_timer.sv
//******************************
// Cluster timer
//******************************

`timescale 1ns/10ps
`default_nettype none

module cluster_timer
  import cluster_periph_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     req_i,
  input  logic                     write_i,
  input  logic [REG_IDX_WIDTH-1:0] reg_idx_i,
  input  logic [DATA_WIDTH-1:0]    wdata_i,
  output logic [DATA_WIDTH-1:0]    rdata_o,
  output logic                     bad_reg_o,
  output logic                     event_o
);

  logic                  enable_q;
  logic [DATA_WIDTH-1:0] count_q;
  logic [DATA_WIDTH-1:0] cmp_q;
  logic                  event_q;
  logic                  wr_en;
  logic                  match;

  assign wr_en = req_i && write_i;
  // Compare only while running
  assign match = enable_q && (count_q == cmp_q);

  always_comb begin
    rdata_o   = '0;
    bad_reg_o = 1'b0;
    case (reg_idx_i)
      TIMER_CFG:   rdata_o = DATA_WIDTH'(enable_q);
      TIMER_COUNT: rdata_o = count_q;
      TIMER_CMP:   rdata_o = cmp_q;
      default:     bad_reg_o = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q <= 1'b0;
      count_q  <= '0;
      cmp_q    <= '0;
      event_q  <= 1'b0;
    end else begin
      event_q <= match;
      if (wr_en && (reg_idx_i == TIMER_CFG)) begin
        enable_q <= wdata_i[0];
      end
      if (wr_en && (reg_idx_i == TIMER_CMP)) begin
        cmp_q <= wdata_i;
      end
      // A software load wins over the reload and the increment
      if (wr_en && (reg_idx_i == TIMER_COUNT)) begin
        count_q <= wdata_i;
      end else if (match) begin
        count_q <= '0;
      end else if (enable_q) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign event_o = event_q;

endmodule

`default_nettype wire

//--- source/cluster_ctrl_unit.sv
//******************************
// Cluster control unit
//******************************

`timescale 1ns/10ps
`default_nettype none

module cluster_ctrl_unit
  import cluster_periph_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                req_i,
  input  logic                                write_i,
  input  logic [REG_IDX_WIDTH-1:0]            reg_idx_i,
  input  logic [DATA_WIDTH-1:0]               wdata_i,
  output logic [DATA_WIDTH-1:0]               rdata_o,
  output logic                                bad_reg_o,
  output logic                                eoc_o,
  output logic [NB_CORES-1:0]                 fetch_enable_o,
  output logic [NB_CORES-1:0][DATA_WIDTH-1:0] boot_addr_o
);

  logic                                eoc_q;
  logic [NB_CORES-1:0]                 fetch_en_q;
  logic [NB_CORES-1:0][DATA_WIDTH-1:0] boot_addr_q;

  // Register read mux, boot addresses follow CTRL_BOOT_ADDR
  always_comb begin
    rdata_o   = '0;
    bad_reg_o = 1'b0;
    case (reg_idx_i)
      CTRL_EOC:      rdata_o = DATA_WIDTH'(eoc_q);
      CTRL_FETCH_EN: rdata_o = DATA_WIDTH'(fetch_en_q);
      default: begin
        bad_reg_o = 1'b1;
        for (int i = 0; i < NB_CORES; i++) begin
          if (reg_idx_i == REG_IDX_WIDTH'(CTRL_BOOT_ADDR) + REG_IDX_WIDTH'(i)) begin
            rdata_o   = boot_addr_q[i];
            bad_reg_o = 1'b0;
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      eoc_q       <= 1'b0;
      fetch_en_q  <= '0;
      boot_addr_q <= {NB_CORES{BOOT_ADDR_RESET}};
    end else if (req_i && write_i) begin
      case (reg_idx_i)
        CTRL_EOC:      eoc_q      <= wdata_i[0];
        CTRL_FETCH_EN: fetch_en_q <= wdata_i[NB_CORES-1:0];
        default: begin
          for (int i = 0; i < NB_CORES; i++) begin
            if (reg_idx_i == REG_IDX_WIDTH'(CTRL_BOOT_ADDR) + REG_IDX_WIDTH'(i)) begin
              boot_addr_q[i] <= wdata_i;
            end
          end
        end
      endcase
    end
  end

  assign eoc_o          = eoc_q;
  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_addr_q;

endmodule

`default_nettype wire

//--- source/periph_bus_demux.sv
//******************************
// Peripheral bus demultiplexer
//******************************

`timescale 1ns/10ps
`default_nettype none

module periph_bus_demux
  import cluster_periph_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  input  logic                     req_i,
  input  logic [DATA_WIDTH-1:0]    add_i,
  input  logic                     wen_i,
  input  logic [DATA_WIDTH-1:0]    wdata_i,
  input  logic [ID_WIDTH-1:0]      id_i,
  output logic                     gnt_o,
  output logic                     r_valid_o,
  output logic [DATA_WIDTH-1:0]    r_rdata_o,
  output logic                     r_opc_o,
  output logic [ID_WIDTH-1:0]      r_id_o,

  output logic                     ctrl_req_o,
  output logic                     timer_req_o,
  output logic                     eu_req_o,
  output logic                     write_o,
  output logic [REG_IDX_WIDTH-1:0] reg_idx_o,
  output logic [DATA_WIDTH-1:0]    wdata_o,
  input  logic [DATA_WIDTH-1:0]    ctrl_rdata_i,
  input  logic                     ctrl_bad_reg_i,
  input  logic [DATA_WIDTH-1:0]    timer_rdata_i,
  input  logic                     timer_bad_reg_i,
  input  logic [DATA_WIDTH-1:0]    eu_rdata_i,
  input  logic                     eu_bad_reg_i
);

  unit_sel_e             unit_sel;
  logic [DATA_WIDTH-1:0] sel_rdata;
  logic                  sel_err;

  // No back-pressure, every request is granted at once
  assign gnt_o     = req_i;
  assign unit_sel  = unit_sel_e'(add_i[UNIT_SEL_LSB +: 2]);
  assign reg_idx_o = add_i[2 +: REG_IDX_WIDTH];
  assign write_o   = ~wen_i;
  assign wdata_o   = wdata_i;

  assign ctrl_req_o  = req_i && (unit_sel == UNIT_CTRL);
  assign timer_req_o = req_i && (unit_sel == UNIT_TIMER);
  assign eu_req_o    = req_i && (unit_sel == UNIT_EVENT);

  // Pick the unit's answer in the grant cycle
  always_comb begin
    sel_rdata = '0;
    sel_err   = 1'b1;
    case (unit_sel)
      UNIT_CTRL: begin
        sel_rdata = ctrl_rdata_i;
        sel_err   = ctrl_bad_reg_i;
      end
      UNIT_TIMER: begin
        sel_rdata = timer_rdata_i;
        sel_err   = timer_bad_reg_i;
      end
      UNIT_EVENT: begin
        sel_rdata = eu_rdata_i;
        sel_err   = eu_bad_reg_i;
      end
      default: begin
        sel_err = 1'b1;
      end
    endcase
    // Writes and errors answer with zero data
    if (sel_err || !wen_i) begin
      sel_rdata = '0;
    end
  end

  //******************************
  // Response stage
  //******************************
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      r_valid_o <= 1'b0;
    end else begin
      r_valid_o <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      r_rdata_o <= sel_rdata;
      r_opc_o   <= sel_err;
      r_id_o    <= id_i;
    end
  end

endmodule

`default_nettype wire

//--- source/cluster_periph_pkg.sv
//******************************
// Cluster peripheral constants
//******************************

`default_nettype none

package cluster_periph_pkg;

  // Cluster size and bus widths
  localparam int unsigned NB_CORES      = 4;
  localparam int unsigned DATA_WIDTH    = 32;
  localparam int unsigned ID_WIDTH      = NB_CORES + 1;

  // Address map, the unit sits in bits 11:10 and the word index in bits 9:2
  localparam int unsigned UNIT_SEL_LSB  = 10;
  localparam int unsigned REG_IDX_WIDTH = 8;

  typedef enum logic [1:0] {
    UNIT_CTRL  = 2'd0,
    UNIT_TIMER = 2'd1,
    UNIT_EVENT = 2'd2,
    UNIT_NONE  = 2'd3
  } unit_sel_e;

  // Control unit, boot address of core i at CTRL_BOOT_ADDR + i
  typedef enum logic [7:0] {
    CTRL_EOC       = 8'd0,
    CTRL_FETCH_EN  = 8'd2,
    CTRL_BOOT_ADDR = 8'd16
  } ctrl_reg_e;

  localparam logic [31:0] BOOT_ADDR_RESET = 32'h1C00_0000;

  typedef enum logic [7:0] {
    TIMER_CFG   = 8'd0,
    TIMER_COUNT = 8'd1,
    TIMER_CMP   = 8'd2
  } timer_reg_e;

  // Event unit offsets within the 4-word block of each core
  typedef enum logic [1:0] {
    EU_MASK         = 2'd0,
    EU_BUFFER       = 2'd1,
    EU_BUFFER_CLEAR = 2'd2
  } eu_reg_e;

  // Event lines and interrupt numbering
  localparam int unsigned NB_EVENTS    = 4;
  localparam int unsigned EVT_MBOX     = 0;
  localparam int unsigned EVT_TIMER    = 1;
  localparam int unsigned EVT_DMA      = 2;
  localparam int unsigned EVT_DMA_IRQ  = 3;
  localparam int unsigned IRQ_ID_WIDTH = 5;
  localparam int unsigned IRQ_ID_BASE  = 16;

endpackage

`default_nettype wire
